//--- source/catch_pkg.sv
package catch_pkg;

    typedef logic [2:0] lane_t;
    typedef logic [9:0] ypos_t;
    typedef logic signed [6:0] score_t;
    typedef logic [8:0] key_code_t; // {extended, scan code}

    typedef enum logic [1:0] {
        GS_IDLE,
        GS_PLAYING,
        GS_WON,
        GS_LOST
    } game_state_e;

    // symbols the scanner can show
    typedef enum logic [3:0] {
        DG_0 = 4'd0, DG_1, DG_2, DG_3, DG_4,
        DG_5, DG_6, DG_7, DG_8, DG_9,
        DG_DASH, DG_E, DG_N, DG_D,
        DG_BLANK = 4'd15
    } digit_code_e;

    // playfield in pixels
    localparam int NUM_LANES = 8;
    localparam int SPRITE_H = 80;
    localparam int CATCH_Y = 400 - SPRITE_H; // item bottom touches farmer row
    localparam int BOTTOM_Y = 476;
    localparam lane_t FARMER_START_LANE = 3'd2;

    localparam key_code_t KEY_LEFT = 9'h01C;  // A
    localparam key_code_t KEY_RIGHT = 9'h023; // D

    localparam int ITEM_YELLOW = 0;
    localparam int ITEM_ORANGE = 1;
    localparam int ITEM_GREEN = 2;
    localparam int ITEM_BUG = 3;
    localparam int NUM_ITEMS = 4;

    localparam score_t ITEM_POINTS [NUM_ITEMS] = '{7'sd1, 7'sd2, 7'sd3, -7'sd3};
    localparam lane_t ITEM_START_LANE [NUM_ITEMS] = '{3'd6, 3'd3, 3'd1, 3'd0};
    localparam int ITEM_STEP_SHIFT [NUM_ITEMS] = '{2, 1, 0, 1}; // log2 base ticks per move

    localparam int WIN_SCORE = 30;
    localparam lane_t LFSR_SEED = 3'b101;

endpackage

//--- source/game_pacer.sv
`timescale 1ns/1ps

module game_pacer import catch_pkg::*; #(
    parameter int BASE_DIV = 2_097_152
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       playing_i,
    output logic       base_tick_o,
    output logic [7:0] tick_idx_o,
    output lane_t      lane_rand_o
);

    localparam int DIV_W = (BASE_DIV > 1) ? $clog2(BASE_DIV) : 1;

    logic [DIV_W-1:0] div_cnt;

    // free running divider, wraps every BASE_DIV cycles
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            div_cnt <= '0;
        end else if (div_cnt == DIV_W'(BASE_DIV - 1)) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    assign base_tick_o = (div_cnt == DIV_W'(BASE_DIV - 1));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tick_idx_o <= '0;
        end else if (!playing_i) begin
            tick_idx_o <= '0;
        end else if (base_tick_o) begin
            tick_idx_o <= tick_idx_o + 8'd1;
        end
    end

    // shared respawn lane source, steps every clock
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lane_rand_o <= LFSR_SEED;
        end else begin
            lane_rand_o <= {lane_rand_o[1] ^ lane_rand_o[0], lane_rand_o[2:1]};
        end
    end

endmodule

//--- source/falling_item.sv
`timescale 1ns/1ps

module falling_item import catch_pkg::*; #(
    parameter lane_t START_LANE = 3'd0,
    parameter int    STEP_SHIFT = 0
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       playing_i,
    input  logic       base_tick_i,
    input  logic [7:0] tick_idx_i,
    input  lane_t      lane_rand_i,
    input  lane_t      farmer_lane_i,
    output logic       catch_o,
    output lane_t      lane_o,
    output ypos_t      y_o
);

    // low tick index bits that must be zero for a move
    localparam logic [7:0] STEP_MASK = 8'((1 << STEP_SHIFT) - 1);

    logic step;
    logic caught;
    logic at_bottom;

    assign step = base_tick_i && ((tick_idx_i & STEP_MASK) == 8'd0);
    assign caught = (lane_o == farmer_lane_i) && (y_o >= ypos_t'(CATCH_Y));
    assign at_bottom = (y_o >= ypos_t'(BOTTOM_Y));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lane_o <= START_LANE;
            y_o <= '0;
            catch_o <= 1'b0;
        end else if (!playing_i) begin
            lane_o <= START_LANE; // parked until the game runs
            y_o <= '0;
            catch_o <= 1'b0;
        end else begin
            catch_o <= 1'b0;
            if (step) begin
                if (caught) begin
                    lane_o <= lane_rand_i;
                    y_o <= '0;
                    catch_o <= 1'b1;
                end else if (!at_bottom) begin
                    y_o <= y_o + ypos_t'(1);
                end else begin
                    // missed, respawn at the top
                    lane_o <= lane_rand_i;
                    y_o <= '0;
                end
            end
        end
    end

endmodule

//--- source/farmer_ctrl.sv
`timescale 1ns/1ps

module farmer_ctrl import catch_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      key_valid_i,
    input  key_code_t key_code_i,
    input  logic      key_break_i,
    output lane_t     farmer_lane_o
);

    localparam lane_t LAST_LANE = lane_t'(NUM_LANES - 1);

    logic make_evt;
    logic go_left;
    logic go_right;

    // only key presses move the farmer
    assign make_evt = key_valid_i && !key_break_i;
    assign go_left = make_evt && (key_code_i == KEY_LEFT) && (farmer_lane_o != '0);
    assign go_right = make_evt && (key_code_i == KEY_RIGHT) && (farmer_lane_o != LAST_LANE);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            farmer_lane_o <= FARMER_START_LANE;
        end else if (go_left) begin
            farmer_lane_o <= farmer_lane_o - lane_t'(1);
        end else if (go_right) begin
            farmer_lane_o <= farmer_lane_o + lane_t'(1);
        end
    end

endmodule

//--- source/game_ctrl.sv
`timescale 1ns/1ps

module game_ctrl import catch_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 start_i,
    input  logic [NUM_ITEMS-1:0] catch_i,
    output logic                 playing_o,
    output game_state_e          game_state_o,
    output score_t               score_o
);

    logic [3:0] start_shift;
    logic       start_db;
    logic       start_db_d;
    logic       start_pulse;
    score_t     catch_sum;
    score_t     score_next;

    assign start_db = &start_shift; // four samples high

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            start_shift <= '0;
            start_db_d <= 1'b0;
            start_pulse <= 1'b0;
        end else begin
            start_shift <= {start_shift[2:0], start_i};
            start_db_d <= start_db;
            start_pulse <= start_db && !start_db_d; // rising edge only
        end
    end

    // points of everything caught this cycle
    always_comb begin
        catch_sum = '0;
        for (int i = 0; i < NUM_ITEMS; i++) begin
            if (catch_i[i]) begin
                catch_sum = catch_sum + ITEM_POINTS[i];
            end
        end
    end

    assign score_next = score_o + catch_sum;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            game_state_o <= GS_IDLE;
            score_o <= '0;
        end else begin
            case (game_state_o)
                GS_IDLE: begin
                    if (start_pulse) begin
                        game_state_o <= GS_PLAYING;
                        score_o <= '0;
                    end
                end
                GS_PLAYING: begin
                    if (|catch_i) begin
                        if (score_next >= WIN_SCORE) begin
                            game_state_o <= GS_WON;
                            score_o <= '0;
                        end else if (score_next < 0) begin
                            game_state_o <= GS_LOST;
                            score_o <= '0;
                        end else begin
                            score_o <= score_next;
                        end
                    end
                end
                default: begin // won or lost
                    if (start_pulse) begin
                        game_state_o <= GS_IDLE;
                    end
                end
            endcase
        end
    end

    assign playing_o = (game_state_o == GS_PLAYING);

endmodule

//--- source/seg_display.sv
`timescale 1ns/1ps

module seg_display import catch_pkg::*; #(
    parameter int SCAN_DIV = 16_384
) (
    input  logic        clk,
    input  logic        rst,
    input  game_state_e game_state_i,
    input  score_t      score_i,
    output logic [3:0]  digit_sel_o,
    output logic [6:0]  seg_o
);

    localparam int SCAN_W = (SCAN_DIV > 1) ? $clog2(SCAN_DIV) : 1;

    logic [SCAN_W-1:0] scan_cnt;
    logic [1:0]        digit_idx; // 0 is units
    logic [6:0]        score_u;
    digit_code_e       sym [4];
    digit_code_e       cur_sym;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            scan_cnt <= '0;
            digit_idx <= '0;
        end else if (scan_cnt == SCAN_W'(SCAN_DIV - 1)) begin
            scan_cnt <= '0;
            digit_idx <= digit_idx + 2'd1;
        end else begin
            scan_cnt <= scan_cnt + 1'b1;
        end
    end

    assign score_u = unsigned'(score_i); // never negative while stored

    always_comb begin
        case (game_state_i)
            GS_IDLE: sym = '{DG_DASH, DG_DASH, DG_DASH, DG_DASH};
            GS_PLAYING: begin
                sym[0] = digit_code_e'(4'(score_u % 7'd10));
                sym[1] = digit_code_e'(4'(score_u / 7'd10));
                sym[2] = DG_BLANK;
                sym[3] = DG_BLANK;
            end
            default: sym = '{DG_D, DG_N, DG_E, DG_BLANK}; // "End" on the right three
        endcase
    end

    assign cur_sym = sym[digit_idx];
    assign digit_sel_o = ~(4'b0001 << digit_idx);

    // segments active low, g in bit 6
    always_comb begin
        case (cur_sym)
            DG_0: seg_o = 7'b100_0000;
            DG_1: seg_o = 7'b111_1001;
            DG_2: seg_o = 7'b010_0100;
            DG_3: seg_o = 7'b011_0000;
            DG_4: seg_o = 7'b001_1001;
            DG_5: seg_o = 7'b001_0010;
            DG_6: seg_o = 7'b000_0010;
            DG_7: seg_o = 7'b111_1000;
            DG_8: seg_o = 7'b000_0000;
            DG_9: seg_o = 7'b001_0000;
            DG_DASH: seg_o = 7'b011_1111;
            DG_E: seg_o = 7'b000_0110;
            DG_N: seg_o = 7'b010_1011;
            DG_D: seg_o = 7'b010_0001;
            default: seg_o = 7'b111_1111;
        endcase
    end

endmodule

//--- source/fruit_catch_top.sv
`timescale 1ns/1ps

module fruit_catch_top import catch_pkg::*; #(
    parameter int BASE_DIV = 2_097_152,
    parameter int SCAN_DIV = 16_384
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        start_i,
    input  logic        key_valid_i,
    input  key_code_t   key_code_i,
    input  logic        key_break_i,
    output logic [6:0]  seg_o,
    output logic [3:0]  digit_sel_o,
    output game_state_e game_state_o,
    output score_t      score_o,
    output lane_t       farmer_lane_o
);

    logic                 playing;
    logic                 base_tick;
    logic [7:0]           tick_idx;
    lane_t                lane_rand;
    logic [NUM_ITEMS-1:0] catch_vec;

    game_pacer #(.BASE_DIV(BASE_DIV)) u_pacer (
        .clk(clk), .rst(rst),
        .playing_i(playing),
        .base_tick_o(base_tick),
        .tick_idx_o(tick_idx),
        .lane_rand_o(lane_rand)
    );

    farmer_ctrl u_farmer (
        .clk(clk), .rst(rst),
        .key_valid_i(key_valid_i),
        .key_code_i(key_code_i),
        .key_break_i(key_break_i),
        .farmer_lane_o(farmer_lane_o)
    );

    // one item per fruit plus the bug, positions unused until rendering returns
    falling_item #(
        .START_LANE(ITEM_START_LANE[ITEM_YELLOW]),
        .STEP_SHIFT(ITEM_STEP_SHIFT[ITEM_YELLOW])
    ) u_item_yellow (
        .clk(clk), .rst(rst), .playing_i(playing), .base_tick_i(base_tick),
        .tick_idx_i(tick_idx), .lane_rand_i(lane_rand), .farmer_lane_i(farmer_lane_o),
        .catch_o(catch_vec[ITEM_YELLOW]), .lane_o(), .y_o()
    );

    falling_item #(
        .START_LANE(ITEM_START_LANE[ITEM_ORANGE]),
        .STEP_SHIFT(ITEM_STEP_SHIFT[ITEM_ORANGE])
    ) u_item_orange (
        .clk(clk), .rst(rst), .playing_i(playing), .base_tick_i(base_tick),
        .tick_idx_i(tick_idx), .lane_rand_i(lane_rand), .farmer_lane_i(farmer_lane_o),
        .catch_o(catch_vec[ITEM_ORANGE]), .lane_o(), .y_o()
    );

    falling_item #(
        .START_LANE(ITEM_START_LANE[ITEM_GREEN]),
        .STEP_SHIFT(ITEM_STEP_SHIFT[ITEM_GREEN])
    ) u_item_green (
        .clk(clk), .rst(rst), .playing_i(playing), .base_tick_i(base_tick),
        .tick_idx_i(tick_idx), .lane_rand_i(lane_rand), .farmer_lane_i(farmer_lane_o),
        .catch_o(catch_vec[ITEM_GREEN]), .lane_o(), .y_o()
    );

    falling_item #(
        .START_LANE(ITEM_START_LANE[ITEM_BUG]),
        .STEP_SHIFT(ITEM_STEP_SHIFT[ITEM_BUG])
    ) u_item_bug (
        .clk(clk), .rst(rst), .playing_i(playing), .base_tick_i(base_tick),
        .tick_idx_i(tick_idx), .lane_rand_i(lane_rand), .farmer_lane_i(farmer_lane_o),
        .catch_o(catch_vec[ITEM_BUG]), .lane_o(), .y_o()
    );

    game_ctrl u_game (
        .clk(clk), .rst(rst),
        .start_i(start_i),
        .catch_i(catch_vec),
        .playing_o(playing),
        .game_state_o(game_state_o),
        .score_o(score_o)
    );

    seg_display #(.SCAN_DIV(SCAN_DIV)) u_disp (
        .clk(clk), .rst(rst),
        .game_state_i(game_state_o),
        .score_i(score_o),
        .digit_sel_o(digit_sel_o),
        .seg_o(seg_o)
    );

endmodule

//--- tb/tb_fruit_catch.sv
`timescale 1ns/1ps

module tb_fruit_catch import catch_pkg::*; ();

    localparam int BASE_DIV = 4;
    localparam int SCAN_DIV = 8;
    localparam lane_t MODEL_SEED = 3'b101;
    // 40 worst case falls of the slowest item plus the scripted part
    localparam int MAX_CYCLES = 40 * BOTTOM_Y * 16 * BASE_DIV + 4000;

    logic        clk, rst, start_i, key_valid_i, key_break_i;
    key_code_t   key_code_i;
    logic [6:0]  seg_o;
    logic [3:0]  digit_sel_o;
    game_state_e game_state_o;
    score_t      score_o;
    lane_t       farmer_lane_o;

    // reference model of the playfield
    int                   m_div, m_score;
    int                   m_y [NUM_ITEMS];
    lane_t                m_lane [NUM_ITEMS];
    lane_t                m_lfsr, m_farmer;
    logic [7:0]           m_idx;
    logic [3:0]           m_start_hist;
    logic                 m_db_d, m_pulse;
    logic [NUM_ITEMS-1:0] m_catch;
    game_state_e          m_state;

    int err_cnt, pass_cnt, fail_cnt, test_no, test_errs, cycle_cnt;

    fruit_catch_top #(.BASE_DIV(BASE_DIV), .SCAN_DIV(SCAN_DIV)) u_dut (
        .clk(clk), .rst(rst), .start_i(start_i), .key_valid_i(key_valid_i),
        .key_code_i(key_code_i), .key_break_i(key_break_i), .seg_o(seg_o),
        .digit_sel_o(digit_sel_o), .game_state_o(game_state_o), .score_o(score_o),
        .farmer_lane_o(farmer_lane_o)
    );

    always #10 clk = ~clk;

    always @(posedge clk or posedge rst) begin : ref_model
        logic                 tick, playing, step;
        int                   sum;
        int                   n_y [NUM_ITEMS];
        lane_t                n_lane [NUM_ITEMS];
        logic [NUM_ITEMS-1:0] n_catch;
        if (rst) begin
            m_div = 0;
            m_idx = '0;
            m_lfsr = MODEL_SEED;
            m_farmer = FARMER_START_LANE;
            m_start_hist = '0;
            m_db_d = 1'b0;
            m_pulse = 1'b0;
            m_state = GS_IDLE;
            m_score = 0;
            m_catch = '0;
            m_lane = ITEM_START_LANE;
            m_y = '{0, 0, 0, 0};
        end else begin
            tick = (m_div == BASE_DIV - 1);
            playing = (m_state == GS_PLAYING);
            sum = 0;
            for (int i = 0; i < NUM_ITEMS; i++) begin
                step = playing && tick && (m_idx % (1 << ITEM_STEP_SHIFT[i]) == 0);
                n_lane[i] = playing ? m_lane[i] : ITEM_START_LANE[i];
                n_y[i] = playing ? m_y[i] : 0;
                n_catch[i] = 1'b0;
                if (step && m_lane[i] == m_farmer && m_y[i] >= CATCH_Y) begin
                    n_lane[i] = m_lfsr;
                    n_y[i] = 0;
                    n_catch[i] = 1'b1;
                end else if (step && m_y[i] < BOTTOM_Y) begin
                    n_y[i] = m_y[i] + 1;
                end else if (step) begin
                    n_lane[i] = m_lfsr; // fell past the farmer
                    n_y[i] = 0;
                end
                if (m_catch[i])
                    sum += ITEM_POINTS[i];
            end
            if (playing && m_catch != '0) begin
                if (m_score + sum >= WIN_SCORE) begin
                    m_state = GS_WON;
                    m_score = 0;
                end else if (m_score + sum < 0) begin
                    m_state = GS_LOST;
                    m_score = 0;
                end else begin
                    m_score = m_score + sum;
                end
            end else if (m_state == GS_IDLE && m_pulse) begin
                m_state = GS_PLAYING;
                m_score = 0;
            end else if (!playing && m_pulse) begin
                m_state = GS_IDLE;
            end
            m_pulse = (&m_start_hist) && !m_db_d;
            m_db_d = &m_start_hist;
            m_start_hist = {m_start_hist[2:0], start_i};
            if (key_valid_i && !key_break_i && key_code_i == KEY_LEFT && m_farmer != 0)
                m_farmer = m_farmer - 1;
            else if (key_valid_i && !key_break_i && key_code_i == KEY_RIGHT && m_farmer != 7)
                m_farmer = m_farmer + 1;
            m_idx = !playing ? 8'd0 : (tick ? m_idx + 8'd1 : m_idx);
            m_div = tick ? 0 : m_div + 1;
            m_lfsr = {m_lfsr[1] ^ m_lfsr[0], m_lfsr[2:1]};
            m_lane = n_lane;
            m_y = n_y;
            m_catch = n_catch;
        end
    end

    function automatic digit_code_e decode_seg(input logic [6:0] seg);
        case (seg)
            7'b100_0000: return DG_0;
            7'b111_1001: return DG_1;
            7'b010_0100: return DG_2;
            7'b011_0000: return DG_3;
            7'b001_1001: return DG_4;
            7'b001_0010: return DG_5;
            7'b000_0010: return DG_6;
            7'b111_1000: return DG_7;
            7'b000_0000: return DG_8;
            7'b001_0000: return DG_9;
            7'b011_1111: return DG_DASH;
            7'b000_0110: return DG_E;
            7'b010_1011: return DG_N;
            7'b010_0001: return DG_D;
            7'b111_1111: return DG_BLANK;
            default: return digit_code_e'(4'd14); // no known symbol
        endcase
    endfunction

    task automatic check_lane(input lane_t got, input lane_t exp, input string what);
        if (got !== exp) begin
            $display("[ERROR] %0d ns: %s lane %0d, expected %0d", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_state(input game_state_e got, input game_state_e exp, input string what);
        if (got !== exp) begin
            $display("[ERROR] %0d ns: %s is %s, expected %s", $time, what, got.name(), exp.name());
            err_cnt++;
        end
    endtask

    task automatic check_score(input score_t got, input score_t exp, input string what);
        if (got !== exp) begin
            $display("[ERROR] %0d ns: %s %0d, expected %0d", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_seg(input digit_code_e got, input digit_code_e exp, input string what);
        if (got !== exp) begin
            $display("[ERROR] %0d ns: %s shows code %0d, expected %s", $time, what, got,
                     exp.name());
            err_cnt++;
        end
    endtask

    task automatic end_test(input string name);
        test_no++;
        if (err_cnt == test_errs) begin
            pass_cnt++;
            $display("test %0d %s: ok", test_no, name);
        end else begin
            fail_cnt++;
            $display("test %0d %s: failed with %0d errors", test_no, name, err_cnt - test_errs);
        end
        test_errs = err_cnt;
    endtask

    task automatic send_key(input key_code_t code, input logic brk);
        key_code_i = code;
        key_break_i = brk;
        key_valid_i = 1'b1;
        @(negedge clk);
        key_valid_i = 1'b0;
    endtask

    task automatic read_digit(input int pos, output digit_code_e sym);
        logic [3:0] sel;
        int         n;
        sel = ~(4'b0001 << pos);
        n = 0;
        while (digit_sel_o !== sel && n < 4 * SCAN_DIV + 4) begin
            @(negedge clk);
            n++;
        end
        if (digit_sel_o !== sel) begin
            $display("digit %0d was never selected by the scanner", pos);
            err_cnt++;
        end
        sym = decode_seg(seg_o);
    endtask

    // lowest fruit that no bug sits under
    function automatic lane_t pick_target();
        int    best;
        lane_t tgt;
        best = -1;
        tgt = (m_lane[ITEM_BUG] == 3'd0) ? 3'd1 : m_lane[ITEM_BUG] - 3'd1;
        for (int i = 0; i < ITEM_BUG; i++) begin
            if (m_y[i] > best &&
                !(m_lane[i] == m_lane[ITEM_BUG] && m_y[ITEM_BUG] >= m_y[i])) begin
                best = m_y[i];
                tgt = m_lane[i];
            end
        end
        return tgt;
    endfunction

    task automatic play_run(input logic steer, input game_state_e final_state);
        int          last_score;
        score_t      last_dut;
        logic        units_due, tens_due;
        lane_t       tgt;
        digit_code_e sym;
        digit_code_e end_sym [4] = '{DG_D, DG_N, DG_E, DG_BLANK};
        while (!steer && m_farmer != 3'd0)
            send_key(KEY_LEFT, 1'b0); // park in lane 0
        last_score = m_score;
        last_dut = score_o;
        units_due = 1'b1;
        tens_due = 1'b1;
        while (m_state == GS_PLAYING) begin
            @(negedge clk);
            if (m_score != last_score || score_o != last_dut) begin
                check_score(score_o, score_t'(m_score), "score");
                last_score = m_score;
                last_dut = score_o;
                units_due = 1'b1;
                tens_due = 1'b1;
            end
            if (m_state != GS_PLAYING || game_state_o != GS_PLAYING) begin
                check_state(game_state_o, m_state, "state");
                break;
            end else if (units_due && digit_sel_o == 4'b1110) begin
                check_seg(decode_seg(seg_o), digit_code_e'(4'(m_score % 10)), "units digit");
                units_due = 1'b0;
            end else if (tens_due && digit_sel_o == 4'b1101) begin
                check_seg(decode_seg(seg_o), digit_code_e'(4'(m_score / 10)), "tens digit");
                tens_due = 1'b0;
            end
            if (key_valid_i) begin
                key_valid_i = 1'b0;
            end else if (steer) begin
                tgt = pick_target();
                if (tgt != m_farmer) begin
                    key_code_i = (tgt < m_farmer) ? KEY_LEFT : KEY_RIGHT;
                    key_break_i = 1'b0;
                    key_valid_i = 1'b1;
                end
            end
        end
        key_valid_i = 1'b0;
        check_state(game_state_o, final_state, "end of run");
        check_score(score_o, '0, "score after run");
        for (int p = 0; p < 4; p++) begin
            read_digit(p, sym);
            check_seg(sym, end_sym[p], "end digit");
        end
    endtask

    task automatic run_step(input logic [63:0] op, input int wait_cyc, input key_code_t code,
                            input logic brk, input int expect_val);
        if (op == "KEY") begin
            send_key(code, brk);
            repeat (wait_cyc) @(negedge clk);
            check_lane(farmer_lane_o, lane_t'(expect_val), "farmer");
            end_test("key event");
        end else if (op == "START") begin
            start_i = 1'b1;
            repeat (wait_cyc) @(negedge clk);
            start_i = 1'b0;
            repeat (6) @(negedge clk);
            check_state(game_state_o, game_state_e'(expect_val), "after start");
            end_test("start button");
        end else if (op == "LOSS" || op == "WIN") begin
            play_run(op == "WIN", game_state_e'(expect_val));
            end_test(op == "WIN" ? "win run" : "loss run");
        end else begin
            $display("unknown step in the test data file");
            err_cnt++;
        end
    endtask

    initial begin : watchdog
        for (cycle_cnt = 0; cycle_cnt < MAX_CYCLES; cycle_cnt++)
            @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin : main
        int          fd, c, wait_cyc, brk, expect_val;
        logic [63:0] op;
        key_code_t   code;
        digit_code_e sym;
        clk = 1'b0;
        rst = 1'b1;
        start_i = 1'b0;
        key_valid_i = 1'b0;
        key_code_i = '0;
        key_break_i = 1'b0;
        err_cnt = 0;
        pass_cnt = 0;
        fail_cnt = 0;
        test_no = 0;
        test_errs = 0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_state(game_state_o, GS_IDLE, "reset state");
        check_score(score_o, '0, "reset score");
        check_lane(farmer_lane_o, FARMER_START_LANE, "reset farmer");
        for (int p = 0; p < 4; p++) begin
            read_digit(p, sym);
            check_seg(sym, DG_DASH, "idle digit");
        end
        end_test("reset");
        fd = $fopen("tb/fruit_catch_testdata.txt", "r");
        if (fd == 0) begin
            $display("the test data file could not be opened");
            err_cnt++;
        end else begin
            while ($fscanf(fd, "%s", op) == 1) begin
                if (op == "#") begin
                    c = 0;
                    while (c != "\n" && c != -1)
                        c = $fgetc(fd);
                end else if ($fscanf(fd, "%d %h %d %d", wait_cyc, code, brk, expect_val) == 4) begin
                    run_step(op, wait_cyc, code, brk, expect_val);
                end else begin
                    $display("a line of the test data file could not be read");
                    err_cnt++;
                end
            end
            $fclose(fd);
        end
        $display("tests passed: %0d, tests failed: %0d, errors: %0d", pass_cnt, fail_cnt,
                 err_cnt);
        if (err_cnt == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- tb/fruit_catch_testdata.txt
# columns: op wait_cycles key_code(hex) break expect
# expect is the farmer lane for KEY and the game state code for START, LOSS and WIN
KEY 1 01c 0 1
KEY 1 01c 0 0
KEY 1 01c 0 0
KEY 1 023 1 0
KEY 2 05a 0 0
KEY 1 11c 0 0
KEY 0 023 0 1
KEY 0 023 0 2
KEY 0 023 0 3
KEY 0 023 0 4
KEY 0 023 0 5
KEY 0 023 0 6
KEY 0 023 0 7
KEY 1 023 0 7
KEY 1 01c 1 7
KEY 1 01c 0 6
# game flow, state codes 0 idle 1 playing 2 won 3 lost
START 2 000 0 0
START 6 000 0 1
LOSS 0 000 0 3
START 6 000 0 0
START 6 000 0 1
WIN 0 000 0 2
START 6 000 0 0

//--- vlog.f
source/catch_pkg.sv
source/game_pacer.sv
source/falling_item.sv
source/farmer_ctrl.sv
source/game_ctrl.sv
source/seg_display.sv
source/fruit_catch_top.sv
tb/tb_fruit_catch.sv

//--- Bender.yml
package:
  name: fruit_catch

sources:
  - files:
      - source/catch_pkg.sv
      - source/game_pacer.sv
      - source/falling_item.sv
      - source/farmer_ctrl.sv
      - source/game_ctrl.sv
      - source/seg_display.sv
      - source/fruit_catch_top.sv
  - target: test
    files:
      - tb/tb_fruit_catch.sv
